//--- logic/vector_pkg.sv
package vector_pkg;

    // word format, signed Q8.24
    localparam int WORD_WIDTH = 32;
    localparam int FRAC_BITS  = 24;

    // 1.0 in Q8.24
    localparam logic [WORD_WIDTH-1:0] FP_ONE = WORD_WIDTH'(1) << FRAC_BITS;

    // table address comes from the top fraction bits
    // of the value normalized to [0.25, 1)
    localparam int LUT_ADDR_BITS = 10;

    // fixed stage latencies in clock cycles
    // sum of squares: products, then adder
    localparam int SUM_LATENCY   = 2;

    // reciprocal square root: normalize, table read, shift back
    localparam int RSQRT_LATENCY = 3;

    // final component multiply
    localparam int SCALE_LATENCY = 1;

    // in_valid to out_valid
    localparam int TOP_LATENCY = SUM_LATENCY + RSQRT_LATENCY + SCALE_LATENCY;

    // signed Q8.24 multiply
    // full 64-bit product, then arithmetic shift by the fraction width
    // result truncated back to one word, no saturation
    // callers keep operands small enough that the integer part fits
    function automatic logic signed [WORD_WIDTH-1:0] fp_mul(
        input logic signed [WORD_WIDTH-1:0] a,
        input logic signed [WORD_WIDTH-1:0] b
    );
        logic signed [2*WORD_WIDTH-1:0] prod;

        // both operands signed, so the product is sign extended
        prod = a * b;
        // slice equals prod >>> FRAC_BITS truncated to a word
        return prod[FRAC_BITS +: WORD_WIDTH];
    endfunction

endpackage

//--- logic/sum_of_squares.sv
`timescale 1ns/1ps

module sum_of_squares (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_x,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_y,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_z,
    output logic                              sum_valid,
    output logic [vector_pkg::WORD_WIDTH-1:0] sum_sq
);
    import vector_pkg::*;

    // stage 1 products
    logic [WORD_WIDTH-1:0] sq_x;
    logic [WORD_WIDTH-1:0] sq_y;
    logic [WORD_WIDTH-1:0] sq_z;
    logic                  valid_s1;

    // stage 1: square each component
    // |c| < 4 keeps every square below 16, no overflow
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sq_x     <= '0;
            sq_y     <= '0;
            sq_z     <= '0;
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
            if (in_valid) begin
                sq_x <= fp_mul(in_x, in_x);
                sq_y <= fp_mul(in_y, in_y);
                sq_z <= fp_mul(in_z, in_z);
            end
        end
    end

    // stage 2: add the three squares
    // sum stays below 48, so sign bit is always clear
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum_sq    <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= valid_s1;
            if (valid_s1) begin
                sum_sq <= sq_x + sq_y + sq_z;
            end
        end
    end

endmodule

//--- logic/invsqrt_rom.sv
`timescale 1ns/1ps

module invsqrt_rom (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 en,
    input  logic [vector_pkg::LUT_ADDR_BITS-1:0] addr,
    output logic [vector_pkg::WORD_WIDTH-1:0]    data_out,
    output logic                                 valid_out
);
    import vector_pkg::*;

    // one entry per address bin of the normalized value
    logic [WORD_WIDTH-1:0] rom_mem [2**LUT_ADDR_BITS];

    // table contents, computed at elaboration
    // address a covers m in [a, a+1) / 2^LUT_ADDR_BITS
    // entry is 1/sqrt(m) at the bin midpoint, rounded to Q8.24
    // bins below 0.25 never get addressed
    initial begin
        real mid;
        real val;

        for (int i = 0; i < 2**LUT_ADDR_BITS; i++) begin
            if (i < 2**(LUT_ADDR_BITS-2)) begin
                rom_mem[i] = '0;
            end else begin
                mid        = (real'(i) + 0.5) / real'(2**LUT_ADDR_BITS);
                val        = real'(FP_ONE) / $sqrt(mid);
                rom_mem[i] = $rtoi(val + 0.5);
            end
        end
    end

    // registered read, valid follows en by one cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_out  <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= en;
            if (en) begin
                data_out <= rom_mem[addr];
            end
        end
    end

endmodule

//--- logic/inv_sqrt.sv
`timescale 1ns/1ps

module inv_sqrt (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_in,
    input  logic [vector_pkg::WORD_WIDTH-1:0] x,
    output logic                              valid_out,
    output logic [vector_pkg::WORD_WIDTH-1:0] inv_sqrt,
    output logic                              zero
);
    import vector_pkg::*;

    // normalize, combinational part
    logic [4:0]               lead_pos;
    logic signed [6:0]        lead_diff;
    logic signed [4:0]        exp_next;
    logic [4:0]               exp_next_mag;
    logic [WORD_WIDTH-1:0]    norm_next;

    // stage 1
    logic [WORD_WIDTH-1:0]    norm_s1;
    logic signed [4:0]        exp_s1;
    logic                     zero_s1;
    logic                     valid_s1;

    // stage 2, beside the table read
    logic signed [4:0]        exp_s2;
    logic                     zero_s2;
    logic [WORD_WIDTH-1:0]    rom_data;
    logic                     rom_valid;

    // stage 3 shift back
    logic [4:0]               exp_s2_mag;
    logic [2*WORD_WIDTH-1:0]  shifted;
    logic [WORD_WIDTH-1:0]    result;

    // priority encoder on the leading one
    // then x = m * 4^e with m in [0.25, 1)
    // so the leading one of m lands on bit FRAC_BITS-1 or FRAC_BITS-2
    // e = floor((lead - (FRAC_BITS-2)) / 2), range -11 .. 4
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            if (x[i]) begin
                lead_pos = 5'(i);
            end
        end
        lead_diff    = $signed({2'b00, lead_pos}) - $signed(7'(FRAC_BITS - 2));
        // arithmetic shift floors toward minus infinity
        exp_next     = 5'(lead_diff >>> 1);
        exp_next_mag = exp_next[4] ? 5'(-exp_next) : 5'(exp_next);
        // shift by 2e keeps the square root exact in the exponent
        if (exp_next[4]) begin
            norm_next = x << {exp_next_mag, 1'b0};
        end else begin
            norm_next = x >> {exp_next_mag, 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            norm_s1  <= '0;
            exp_s1   <= '0;
            zero_s1  <= 1'b0;
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
            if (valid_in) begin
                norm_s1 <= norm_next;
                exp_s1  <= exp_next;
                zero_s1 <= (x == '0);
            end
        end
    end

    // table indexed by the top fraction bits of m
    invsqrt_rom u_rom (
        .clk       (clk),
        .rst       (rst),
        .en        (valid_s1),
        .addr      (norm_s1[FRAC_BITS-1 -: LUT_ADDR_BITS]),
        .data_out  (rom_data),
        .valid_out (rom_valid)
    );

    // exponent and zero flag ride along with the read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exp_s2  <= '0;
            zero_s2 <= 1'b0;
        end else if (valid_s1) begin
            exp_s2  <= exp_s1;
            zero_s2 <= zero_s1;
        end
    end

    // 1/sqrt(x) = 1/sqrt(m) * 2^-e
    // negative e shifts left and can exceed the word for tiny sums,
    // so clamp to the largest positive value
    always_comb begin
        exp_s2_mag = exp_s2[4] ? 5'(-exp_s2) : 5'(exp_s2);
        shifted    = {{WORD_WIDTH{1'b0}}, rom_data};
        if (exp_s2[4]) begin
            shifted = shifted << exp_s2_mag;
        end else begin
            shifted = shifted >> exp_s2_mag;
        end
        if (|shifted[2*WORD_WIDTH-1:WORD_WIDTH-1]) begin
            result = {1'b0, {(WORD_WIDTH-1){1'b1}}};
        end else begin
            result = shifted[WORD_WIDTH-1:0];
        end
    end

    // stage 3 output, zero input forces a zero result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inv_sqrt  <= '0;
            zero      <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= rom_valid;
            if (rom_valid) begin
                inv_sqrt <= zero_s2 ? '0 : result;
                zero     <= zero_s2;
            end
        end
    end

endmodule

//--- logic/vec_scale.sv
`timescale 1ns/1ps

module vec_scale (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_x,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_y,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_z,
    input  logic                              rsqrt_valid,
    input  logic [vector_pkg::WORD_WIDTH-1:0] rsqrt,
    input  logic                              rsqrt_zero,
    output logic                              out_valid,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_x,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_y,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_z,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_rsqrt,
    output logic                              out_zero
);
    import vector_pkg::*;

    // component delay lines
    // depth matches sum plus reciprocal latency
    // last tap lines up with rsqrt_valid
    logic [WORD_WIDTH-1:0] dly_x [SUM_LATENCY + RSQRT_LATENCY];
    logic [WORD_WIDTH-1:0] dly_y [SUM_LATENCY + RSQRT_LATENCY];
    logic [WORD_WIDTH-1:0] dly_z [SUM_LATENCY + RSQRT_LATENCY];

    // loaded only on a real vector, shifted every cycle
    // idle slots carry zeros and never reach the outputs
    always_ff @(posedge clk) begin
        dly_x[0] <= in_valid ? in_x : '0;
        dly_y[0] <= in_valid ? in_y : '0;
        dly_z[0] <= in_valid ? in_z : '0;
        for (int i = 1; i < SUM_LATENCY + RSQRT_LATENCY; i++) begin
            dly_x[i] <= dly_x[i-1];
            dly_y[i] <= dly_y[i-1];
            dly_z[i] <= dly_z[i-1];
        end
    end

    // scale each component by the reciprocal length
    // zero vector gives zero components
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_x     <= '0;
            out_y     <= '0;
            out_z     <= '0;
            out_rsqrt <= '0;
            out_zero  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rsqrt_valid;
            if (rsqrt_valid) begin
                if (rsqrt_zero) begin
                    out_x <= '0;
                    out_y <= '0;
                    out_z <= '0;
                end else begin
                    out_x <= fp_mul(dly_x[SUM_LATENCY + RSQRT_LATENCY - 1], rsqrt);
                    out_y <= fp_mul(dly_y[SUM_LATENCY + RSQRT_LATENCY - 1], rsqrt);
                    out_z <= fp_mul(dly_z[SUM_LATENCY + RSQRT_LATENCY - 1], rsqrt);
                end
                // reciprocal already zero for a zero sum
                out_rsqrt <= rsqrt;
                out_zero  <= rsqrt_zero;
            end
        end
    end

endmodule

//--- logic/vec_norm_top.sv
`timescale 1ns/1ps

module vec_norm_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_x,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_y,
    input  logic [vector_pkg::WORD_WIDTH-1:0] in_z,
    output logic                              out_valid,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_x,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_y,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_z,
    output logic [vector_pkg::WORD_WIDTH-1:0] out_rsqrt,
    output logic                              out_zero
);
    import vector_pkg::*;

    // sum of squares to reciprocal
    logic                  sum_valid;
    logic [WORD_WIDTH-1:0] sum_sq;

    // reciprocal to scaler
    logic                  rsqrt_valid;
    logic [WORD_WIDTH-1:0] rsqrt;
    logic                  rsqrt_zero;

    // 2 cycles
    sum_of_squares u_sum (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_z      (in_z),
        .sum_valid (sum_valid),
        .sum_sq    (sum_sq)
    );

    // 3 cycles
    inv_sqrt u_rsqrt (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (sum_valid),
        .x         (sum_sq),
        .valid_out (rsqrt_valid),
        .inv_sqrt  (rsqrt),
        .zero      (rsqrt_zero)
    );

    // 1 cycle, components delayed inside to meet rsqrt
    vec_scale u_scale (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_x        (in_x),
        .in_y        (in_y),
        .in_z        (in_z),
        .rsqrt_valid (rsqrt_valid),
        .rsqrt       (rsqrt),
        .rsqrt_zero  (rsqrt_zero),
        .out_valid   (out_valid),
        .out_x       (out_x),
        .out_y       (out_y),
        .out_z       (out_z),
        .out_rsqrt   (out_rsqrt),
        .out_zero    (out_zero)
    );

endmodule

//--- dv/vec_norm_checker.sv
`timescale 1ns/1ps

module vec_norm_checker (
    input logic                              clk,
    input logic                              rst,
    input logic                              in_valid,
    input logic                              out_valid,
    input logic [vector_pkg::WORD_WIDTH-1:0] out_x,
    input logic [vector_pkg::WORD_WIDTH-1:0] out_y,
    input logic [vector_pkg::WORD_WIDTH-1:0] out_z,
    input logic [vector_pkg::WORD_WIDTH-1:0] out_rsqrt,
    input logic                              out_zero
);
    import vector_pkg::*;

    // in_valid history, cleared by reset
    logic [TOP_LATENCY-1:0] valid_hist;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[TOP_LATENCY-2:0], in_valid};
        end
    end

    // no output strobe while reset is held
    reset_quiet: assert property (@(posedge clk) !rst |-> !out_valid)
        else $error("out_valid high during reset");

    // fixed pipeline depth, one output per input
    latency_match: assert property (@(posedge clk) disable iff (!rst)
        out_valid == valid_hist[TOP_LATENCY-1])
        else $error("out_valid does not follow in_valid by the pipeline depth");

    // zero vector forces every output to zero
    zero_outputs: assert property (@(posedge clk) disable iff (!rst)
        out_zero |-> (out_x == '0 && out_y == '0 && out_z == '0 && out_rsqrt == '0))
        else $error("out_zero high with a nonzero output");

    valid_known: assert property (@(posedge clk) !$isunknown(out_valid))
        else $error("out_valid unknown");

endmodule

//--- dv/tb_vec_norm.sv
`timescale 1ns/1ps

module tb_vec_norm;
    import vector_pkg::*;

    // test sizes
    localparam int RESET_CYCLES = 4;
    localparam int RESET_IDLE   = 10;
    localparam int N_SINGLE     = 8;
    localparam int N_RANDOM     = 300;
    localparam int N_EXPONENT   = 200;
    localparam int N_ZERO_MIX   = 40;
    localparam int N_GAPPED     = 100;
    localparam int MAX_GAP      = 3;
    localparam real RSQRT_REL_TOL = 0.002;
    localparam real COMP_ABS_TOL  = 0.004;
    // component magnitude ranges in Q8.24: [1/16, 4), [2, 4), [0, 4)
    localparam logic [31:0] MAG_MIN  = 32'h0010_0000;
    localparam logic [31:0] MAG_SPAN = 32'h03F0_0000;
    localparam logic [31:0] TWO      = 32'h0200_0000;
    localparam logic [31:0] FOUR     = 32'h0400_0000;
    // one term per test, the gapped test counts its idle slots too
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (RESET_IDLE + TOP_LATENCY + 20)
        + (N_SINGLE + TOP_LATENCY + 20) + (N_RANDOM + TOP_LATENCY + 20)
        + (N_EXPONENT + TOP_LATENCY + 20) + (N_ZERO_MIX + TOP_LATENCY + 20)
        + (N_GAPPED * (MAX_GAP + 1) + TOP_LATENCY + 20);

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_x;
    logic [31:0] in_y;
    logic [31:0] in_z;
    logic        out_valid;
    logic [31:0] out_x;
    logic [31:0] out_y;
    logic [31:0] out_z;
    logic [31:0] out_rsqrt;
    logic        out_zero;

    // expected results, oldest first
    real exp_rsqrt_q[$];
    real exp_x_q[$];
    real exp_y_q[$];
    real exp_z_q[$];
    bit  exp_zero_q[$];

    logic [31:0] rng_state;
    string       cur_test;
    int          check_count;
    int          error_count;
    int          test_in;
    int          test_out;
    int          test_err_base;

    vec_norm_top uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_z      (in_z),
        .out_valid (out_valid),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_z     (out_z),
        .out_rsqrt (out_rsqrt),
        .out_zero  (out_zero)
    );

    bind vec_norm_top vec_norm_checker u_checker (
        .clk(clk), .rst(rst), .in_valid(in_valid), .out_valid(out_valid),
        .out_x(out_x), .out_y(out_y), .out_z(out_z),
        .out_rsqrt(out_rsqrt), .out_zero(out_zero)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // xorshift32, one step per call
    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // magnitude in [base, base+span) shifted down by sh, random sign
    function automatic logic [31:0] random_component(input logic [31:0] base,
            input logic [31:0] span, input int sh);
        logic [31:0] mag;
        logic [31:0] sgn;
        mag = (base + next_random() % span) >> sh;
        sgn = next_random();
        return sgn[31] ? -mag : mag;
    endfunction

    function automatic real to_real(input logic [31:0] v);
        return real'($signed(v)) / 16777216.0;
    endfunction

    function automatic logic [31:0] to_fixed(input real r);
        return $rtoi(r * 16777216.0);
    endfunction

    task automatic compare_value(input string what, input real expected, input real actual,
            input real tol);
        check_count++;
        if ((actual - expected > tol) || (expected - actual > tol)) begin
            error_count++;
            $display("error: test %s %s expected %0.6f actual %0.6f",
                     cur_test, what, expected, actual);
        end
    endtask

    // drive one vector and queue what should come out
    task automatic send_vector(input logic [31:0] vx, input logic [31:0] vy,
            input logic [31:0] vz);
        real rx;
        real ry;
        real rz;
        real s;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_x     = vx;
        in_y     = vy;
        in_z     = vz;
        test_in++;
        rx = to_real(vx);
        ry = to_real(vy);
        rz = to_real(vz);
        s  = rx * rx + ry * ry + rz * rz;
        exp_zero_q.push_back(s == 0.0);
        // zero vector expects all zeros
        if (s == 0.0) begin
            exp_rsqrt_q.push_back(0.0);
            exp_x_q.push_back(0.0);
            exp_y_q.push_back(0.0);
            exp_z_q.push_back(0.0);
        end else begin
            exp_rsqrt_q.push_back(1.0 / $sqrt(s));
            exp_x_q.push_back(rx / $sqrt(s));
            exp_y_q.push_back(ry / $sqrt(s));
            exp_z_q.push_back(rz / $sqrt(s));
        end
    endtask

    // idle slot, data lines carry junk that must be ignored
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_x     = next_random();
        in_y     = next_random();
        in_z     = next_random();
    endtask

    // wait for the pipeline to empty, bounded by its depth
    task automatic drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_rsqrt_q.size() != 0 && waited < TOP_LATENCY + 4) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_in       = 0;
        test_out      = 0;
        test_err_base = error_count;
    endtask

    task automatic end_test();
        if (exp_rsqrt_q.size() != 0) begin
            error_count++;
            $display("test %s ended with %0d results that never came out",
                     cur_test, exp_rsqrt_q.size());
            exp_rsqrt_q.delete();
            exp_x_q.delete();
            exp_y_q.delete();
            exp_z_q.delete();
            exp_zero_q.delete();
        end
        compare_value("output count", real'(test_in), real'(test_out), 0.0);
        $display("test %-15s vectors %0d outputs %0d errors %0d",
                 cur_test, test_in, test_out, error_count - test_err_base);
    endtask

    task automatic check_output();
        real tol;
        test_out++;
        if (exp_rsqrt_q.size() == 0) begin
            error_count++;
            $display("test %s got out_valid with no vector waiting for a result", cur_test);
        end else begin
            tol = exp_zero_q[0] ? 0.0 : COMP_ABS_TOL;
            compare_value("out_zero", exp_zero_q.pop_front() ? 1.0 : 0.0,
                          out_zero ? 1.0 : 0.0, 0.0);
            compare_value("out_rsqrt", exp_rsqrt_q[0], to_real(out_rsqrt),
                          exp_rsqrt_q[0] * RSQRT_REL_TOL);
            compare_value("out_x", exp_x_q.pop_front(), to_real(out_x), tol);
            compare_value("out_y", exp_y_q.pop_front(), to_real(out_y), tol);
            compare_value("out_z", exp_z_q.pop_front(), to_real(out_z), tol);
            exp_rsqrt_q.pop_front();
        end
    endtask

    // outputs are stable mid cycle
    always @(negedge clk) begin
        if (rst && out_valid) check_output();
    end

    initial begin
        int gap;
        rng_state   = 32'd23;
        rst         = 1'b0;
        in_valid    = 1'b0;
        in_x        = '0;
        in_y        = '0;
        in_z        = '0;
        check_count = 0;
        error_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        // quiet outputs straight after reset
        start_test("reset");
        repeat (RESET_IDLE) begin
            @(negedge clk);
            compare_value("out_valid", 0.0, out_valid ? 1.0 : 0.0, 0.0);
            compare_value("out_zero", 0.0, out_zero ? 1.0 : 0.0, 0.0);
            compare_value("out_rsqrt", 0.0, to_real(out_rsqrt), 0.0);
            compare_value("out_x", 0.0, to_real(out_x), 0.0);
            compare_value("out_y", 0.0, to_real(out_y), 0.0);
            compare_value("out_z", 0.0, to_real(out_z), 0.0);
        end
        end_test();

        // axis vectors and hand picked cases
        start_test("single");
        send_vector(to_fixed(1.0), to_fixed(0.0), to_fixed(0.0));
        send_vector(to_fixed(0.0), to_fixed(1.0), to_fixed(0.0));
        send_vector(to_fixed(0.0), to_fixed(0.0), to_fixed(-1.0));
        send_vector(to_fixed(3.0), to_fixed(4.0), to_fixed(0.0));
        send_vector(to_fixed(1.0), to_fixed(1.0), to_fixed(1.0));
        send_vector(to_fixed(0.5), to_fixed(-0.5), to_fixed(0.25));
        send_vector(to_fixed(-2.0), to_fixed(3.0), to_fixed(-1.0));
        send_vector(to_fixed(0.0), to_fixed(0.0), to_fixed(-3.5));
        drain();
        end_test();

        // back to back stream
        start_test("random_stream");
        for (int i = 0; i < N_RANDOM; i++) begin
            send_vector(random_component(MAG_MIN, MAG_SPAN, 0),
                        random_component(MAG_MIN, MAG_SPAN, 0),
                        random_component(MAG_MIN, MAG_SPAN, 0));
        end
        drain();
        end_test();

        // shifts 0..6 spread sums from about 2^-10 to 48
        start_test("exponent_range");
        for (int i = 0; i < N_EXPONENT; i++) begin
            gap = int'(next_random() % 32'd7);
            send_vector(random_component(TWO, TWO, gap),
                        random_component('0, FOUR, gap),
                        random_component('0, FOUR, gap));
        end
        drain();
        end_test();

        start_test("zero_vector");
        for (int i = 0; i < N_ZERO_MIX; i++) begin
            if (i == 10 || i == 25) begin
                send_vector('0, '0, '0);
            end else begin
                send_vector(random_component(MAG_MIN, MAG_SPAN, 0),
                            random_component(MAG_MIN, MAG_SPAN, 0),
                            random_component(MAG_MIN, MAG_SPAN, 0));
            end
        end
        drain();
        end_test();

        // random idle slots between vectors
        start_test("gapped_valid");
        for (int i = 0; i < N_GAPPED; i++) begin
            gap = int'(next_random() % 32'(MAX_GAP + 1));
            repeat (gap) idle_cycle();
            send_vector(random_component(MAG_MIN, MAG_SPAN, 0),
                        random_component(MAG_MIN, MAG_SPAN, 0),
                        random_component(MAG_MIN, MAG_SPAN, 0));
        end
        drain();
        end_test();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout in test %s, results still missing after %0d cycles",
                 cur_test, WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
logic/vector_pkg.sv
logic/sum_of_squares.sv
logic/invsqrt_rom.sv
logic/inv_sqrt.sv
logic/vec_scale.sv
logic/vec_norm_top.sv
dv/vec_norm_checker.sv
dv/tb_vec_norm.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vector normalizer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_vec_norm \
    -f verilog.f -o tb_vec_norm || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_vec_norm)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
